// File: filelist.f
+incdir+dv
common/jpegPkg.sv
common/decodePkg.sv
huffDecode/huffTableBank.sv
huffDecode/codeMatcher.sv
huffDecode/blockSequencer.sv
logic/coefReconstruct.sv
logic/huffDecodeTop.sv
dv/huffDecodeTb.sv

// File: run.sh
#!/bin/bash
# Build and run the Huffman decoder testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module huffDecodeTb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/VhuffDecodeTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "No errors" sim.log; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed"
exit 1

// File: dv/huffDecodeModel.svh
// Testbench Huffman tables, symbol and quantiser memories, and reference functions
`ifndef HUFF_DECODE_MODEL_SVH
`define HUFF_DECODE_MODEL_SVH

// ------------------------------------------------------------
// Model data
// ------------------------------------------------------------
// Codes per length, same shape for all four classes
int codeCount [16] = '{0, 2, 3, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
logic [7:0] dcSyms [6] = '{8'h02, 8'h03, 8'h00, 8'h01, 8'h05, 8'h08};   // Size only
logic [7:0] acSyms [6] = '{8'h00, 8'h01, 8'h12, 8'hF0, 8'h33, 8'h05};   // EOB at 0, ZRL at 3

jpegPkg::huffCode minTab [4][16];
jpegPkg::symIndex baseTab [4][16];
logic [7:0] symMem [256];               // Run in the upper nibble, size below
jpegPkg::quantVal quantMem [128];       // Chroma bit, then position
int dcPred [3];
integer seed = 32'h8bc7;

// Canonical tables, class c keeps its symbols at c * 16
function automatic void buildModel();
	int code;
	int k;
	for (int a = 0; a < 256; a++) begin
		symMem[a] = 8'(a ^ (a >> 3) ^ 8'hA5);
	end
	for (int a = 0; a < 128; a++) begin
		quantMem[a] = jpegPkg::quantVal'(1 + (a * 7 + a / 16) % 13);
	end
	for (int c = 0; c < 4; c++) begin
		code = 0;
		k = c * 16;
		for (int l = 0; l < 16; l++) begin
			minTab[c][l] = jpegPkg::huffCode'(code << (15 - l));   // Left-aligned
			baseTab[c][l] = jpegPkg::symIndex'(k);
			k += codeCount[l];
			code = (code + codeCount[l]) << 1;
		end
		for (int s = 0; s < 6; s++) begin
			symMem[c * 16 + s] = c[0] ? acSyms[s] : dcSyms[s];
		end
	end
endfunction

// ------------------------------------------------------------
// Reference functions
// ------------------------------------------------------------
function automatic void encodeSym(input int cls, input int sym, output int code, output int len);
	int k;
	k = sym;
	code = 0;
	len = 0;
	for (int l = 0; l < 16; l++) begin
		if (len == 0 && k < codeCount[l]) begin
			len = l + 1;
			code = int'(minTab[cls][l] >> (15 - l)) + k;
		end else if (len == 0) begin
			k -= codeCount[l];
		end
	end
endfunction

// Code, then amplitude bits, then random filler
function automatic jpegPkg::bitWindow buildWindow(input int code, input int len,
	input int size, input int amp);
	jpegPkg::bitWindow bits;
	jpegPkg::bitWindow filler;
	bits = (amp < 0) ? jpegPkg::bitWindow'(amp + (1 << size) - 1) : jpegPkg::bitWindow'(amp);
	filler = $random(seed);
	return (jpegPkg::bitWindow'(code) << (32 - len)) | (bits << (32 - len - size))
		| (filler >> (len + size));
endfunction

function automatic jpegPkg::coefVal expectCoef(input int blk, input int pos, input int amp);
	int comp;
	int val;
	comp = (blk <= 3) ? 0 : (blk == 5) ? 2 : 1;
	val = amp;
	if (pos == 0) begin
		dcPred[comp] += amp;                // DC is a difference
		val = dcPred[comp];
	end
	return jpegPkg::coefVal'(val * int'(quantMem[(blk > 3 ? 64 : 0) + pos]));
endfunction

`endif

// File: dv/huffDecodeTb.sv
// Huffman decoder testbench with clock, reset, table load, stimulus rows, checks and timeout
`timescale 1ns/1ns

module huffDecodeTb;

	// Symbol in local table order, its amplitude and where it lands
	typedef struct packed {
		bit restart;                        // New scan before this row
		bit stall;                          // outIdle low for a while
		int sym;
		int amp;
		int blk;
		int pos;                            // Decoder position for EOB and ZRL
	} stimRow;

	logic clk = 1'b0;
	logic rst;
	logic tableWrite;
	jpegPkg::tableClass tableWrClass;
	jpegPkg::codeLen tableWrLen;
	jpegPkg::huffCode tableWrCode;
	jpegPkg::symIndex tableWrBase;
	logic scanRun;
	logic bitsValid;
	logic outIdle;
	jpegPkg::bitWindow bitsIn;
	jpegPkg::tableClass symClass;
	jpegPkg::symIndex symAddr;
	jpegPkg::runLen symRun;
	jpegPkg::ampSize symSize;
	logic quantChroma;
	jpegPkg::coefPos quantPos;
	jpegPkg::quantVal quantData;
	logic bitsUsed;
	logic coefValid;
	logic blockDone;
	jpegPkg::useWidth bitsUsedWidth;
	jpegPkg::blockId coefBlock;
	jpegPkg::blockId doneBlock;
	jpegPkg::coefPos coefPos;
	jpegPkg::runLen coefRun;
	jpegPkg::coefVal coefData;
	stimRow rows [$];
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int cycleLimit = 1000;

	`include "huffDecodeModel.svh"

	always #50 clk = ~clk;

	// External memories answer in the same cycle
	assign symRun = symMem[symAddr][7:4];
	assign symSize = symMem[symAddr][3:0];
	assign quantData = quantMem[{quantChroma, quantPos}];

	huffDecodeTop DUT (.*);

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycleLimit) begin
			$display("timeout: decoder gave no answer within %0d cycles", cycleLimit);
			$display("Errors found");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------
	task automatic reportMismatch(input string msg);
		errors++;
		$display("mismatch at %0t: %s", $time, msg);
	endtask

	task automatic checkCoef(input jpegPkg::coefVal got, input jpegPkg::coefVal exp);
		checks++;
		if (got !== exp) begin
			reportMismatch($sformatf("coefData %0d, expected %0d", got, exp));
		end
	endtask

	task automatic checkWidth(input jpegPkg::useWidth got, input jpegPkg::useWidth exp);
		checks++;
		if (got !== exp) begin
			reportMismatch($sformatf("bitsUsedWidth %0d, expected %0d", got, exp));
		end
	endtask

	task automatic checkBlock(input string name, input jpegPkg::blockId got,
		input jpegPkg::blockId exp);
		checks++;
		if (got !== exp) begin
			reportMismatch($sformatf("%s %0d, expected %0d", name, got, exp));
		end
	endtask

	task automatic checkPos(input jpegPkg::coefPos got, input jpegPkg::coefPos exp);
		checks++;
		if (got !== exp) begin
			reportMismatch($sformatf("coefPos %0d, expected %0d", got, exp));
		end
	endtask

	task automatic checkRun(input jpegPkg::runLen got, input jpegPkg::runLen exp);
		checks++;
		if (got !== exp) begin
			reportMismatch($sformatf("coefRun %0d, expected %0d", got, exp));
		end
	endtask

	task automatic checkClass(input jpegPkg::tableClass got, input jpegPkg::tableClass exp);
		checks++;
		if (got !== exp) begin
			reportMismatch($sformatf("symClass %0d, expected %0d", got, exp));
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			reportMismatch($sformatf("%s %0b, expected %0b", name, got, exp));
		end
	endtask

	task automatic addRow(input bit restart, input bit stall, input int sym, input int amp,
		input int blk, input int pos);
		rows.push_back(stimRow'{restart, stall, sym, amp, blk, pos});
	endtask

	// ------------------------------------------------------------
	// Stimulus table
	// ------------------------------------------------------------
	task automatic fillRows();
		addRow(0, 0, 1, 5, 0, 0);           // Luma DC, block 0
		addRow(0, 0, 1, -1, 0, 1);
		addRow(0, 0, 2, 3, 0, 3);           // Run 1
		addRow(0, 0, 4, -6, 0, 7);          // Run 3
		addRow(0, 0, 3, 0, 0, 8);           // ZRL
		addRow(0, 1, 5, 20, 0, 24);
		addRow(0, 0, 0, 0, 0, 25);          // EOB
		addRow(0, 0, 0, -3, 1, 0);          // Luma predictor chain
		addRow(0, 0, 0, 0, 1, 1);
		addRow(0, 0, 2, 0, 2, 0);           // Size 0 DC
		addRow(0, 0, 0, 0, 2, 1);
		addRow(0, 0, 3, 1, 3, 0);
		addRow(0, 0, 0, 0, 3, 1);
		addRow(0, 0, 4, -17, 4, 0);         // Cb
		addRow(0, 0, 1, 1, 4, 1);
		addRow(0, 0, 0, 0, 4, 2);
		addRow(0, 0, 5, 200, 5, 0);         // Cr
		addRow(0, 0, 0, 0, 5, 1);
		addRow(0, 0, 1, -4, 0, 0);          // Next MCU
		addRow(0, 0, 0, 0, 0, 1);
		addRow(1, 0, 0, 2, 0, 0);           // Predictors from zero
		addRow(0, 0, 0, 0, 0, 1);
		addRow(0, 1, 4, -16, 1, 0);
	endtask

	initial begin
		stimRow row;
		int cls;
		int code;
		int len;
		int size;
		int errBefore;
		logic [7:0] symb;
		logic expEmit;
		logic expDone;
		buildModel();
		fillRows();
		cycleLimit = rows.size() * 10 + 4 * jpegPkg::NumCodeLens + 100;
		rst = 1'b0;
		tableWrite = 1'b0;
		tableWrClass = '0;
		tableWrLen = '0;
		tableWrCode = '0;
		tableWrBase = '0;
		scanRun = 1'b0;
		bitsValid = 1'b0;
		bitsIn = '0;
		outIdle = 1'b1;
		repeat (3) @(negedge clk);
		rst = 1'b1;
		for (int c = 0; c < 4; c++) begin
			for (int l = 0; l < jpegPkg::NumCodeLens; l++) begin
				@(negedge clk);
				tableWrite = 1'b1;
				tableWrClass = jpegPkg::tableClass'(c);
				tableWrLen = jpegPkg::codeLen'(l);
				tableWrCode = minTab[c][l];
				tableWrBase = baseTab[c][l];
			end
		end
		@(negedge clk);
		tableWrite = 1'b0;
		scanRun = 1'b1;
		foreach (rows[r]) begin
			row = rows[r];
			errBefore = errors;
			if (row.restart) begin
				scanRun = 1'b0;
				repeat (2) @(negedge clk);
				scanRun = 1'b1;
				dcPred = '{0, 0, 0};
			end
			cls = (row.blk > 3 ? 2 : 0) + (row.pos != 0 ? 1 : 0);
			symb = symMem[cls * 16 + row.sym];
			size = int'(symb[3:0]);
			// EOB and ZRL only exist at AC positions
			expEmit = !(row.pos != 0 && size == 0 && (symb[7:4] == 0 || symb[7:4] == 15));
			expDone = (row.pos != 0 && symb == 8'h00) || (expEmit && row.pos == 63);
			encodeSym(cls, row.sym, code, len);
			bitsIn = buildWindow(code, len, size, row.amp);
			bitsValid = 1'b1;
			if (row.stall) begin
				outIdle = 1'b0;
				repeat (8) begin
					@(negedge clk);
					checkFlag("coefValid during stall", coefValid, 1'b0);
					checkFlag("bitsUsed during stall", bitsUsed, 1'b0);
				end
				outIdle = 1'b1;
			end
			while (!bitsUsed) begin
				@(negedge clk);
			end
			checkWidth(bitsUsedWidth, jpegPkg::useWidth'(len + size));
			checkClass(symClass, jpegPkg::tableClass'(cls));
			bitsValid = 1'b0;
			@(negedge clk);
			checkFlag("coefValid", coefValid, expEmit);
			if (expEmit) begin
				checkCoef(coefData, expectCoef(row.blk, row.pos, row.amp));
				checkPos(coefPos, jpegPkg::coefPos'(row.pos));
				checkRun(coefRun, jpegPkg::runLen'(symb[7:4]));
				checkBlock("coefBlock", coefBlock, jpegPkg::blockId'(row.blk));
			end
			@(negedge clk);
			checkFlag("blockDone", blockDone, expDone);
			if (expDone) begin
				checkBlock("doneBlock", doneBlock, jpegPkg::blockId'(row.blk));
			end
			$display("row %0d block %0d pos %0d: %s", r, row.blk, row.pos,
				(errors == errBefore) ? "ok" : "failed");
		end
		$display("%0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// File: logic/huffDecodeTop.sv
// Huffman decoder top level with table bank, matcher, sequencer and reconstruct
`timescale 1ns/1ns

module huffDecodeTop (
	input  logic clk,
	input  logic rst,
	input  logic tableWrite,
	input  jpegPkg::tableClass tableWrClass,
	input  jpegPkg::codeLen tableWrLen,
	input  jpegPkg::huffCode tableWrCode,
	input  jpegPkg::symIndex tableWrBase,
	input  logic scanRun,
	input  logic bitsValid,
	input  jpegPkg::bitWindow bitsIn,
	input  logic outIdle,
	output jpegPkg::tableClass symClass,
	output jpegPkg::symIndex symAddr,
	input  jpegPkg::runLen symRun,
	input  jpegPkg::ampSize symSize,
	output logic quantChroma,
	output jpegPkg::coefPos quantPos,
	input  jpegPkg::quantVal quantData,
	output logic bitsUsed,
	output jpegPkg::useWidth bitsUsedWidth,
	output logic coefValid,
	output jpegPkg::blockId coefBlock,
	output jpegPkg::coefPos coefPos,
	output jpegPkg::runLen coefRun,
	output jpegPkg::coefVal coefData,
	output logic blockDone,
	output jpegPkg::blockId doneBlock
);

	jpegPkg::huffCode minCodes [jpegPkg::NumCodeLens];
	jpegPkg::symIndex baseIndex [jpegPkg::NumCodeLens];
	jpegPkg::tableClass rdClass;
	jpegPkg::bitWindow window;
	jpegPkg::codeLen matchLen;
	jpegPkg::coefVal amplitude;
	logic readBusy;
	logic compareEn;
	logic selectEn;
	logic predictEn;
	logic isDc;
	logic [1:0] component;

	assign symClass = rdClass;              // Same class as the code table
	assign quantChroma = rdClass[1];
	assign quantPos = coefPos;

	huffTableBank tableBank (.clk, .rst, .tableWrite, .tableWrClass, .tableWrLen,
		.tableWrCode, .tableWrBase, .rdClass, .readBusy, .minCodes, .baseIndex);

	codeMatcher matcher (.clk, .rst, .compareEn, .selectEn, .window, .minCodes,
		.baseIndex, .matchLen, .symAddr);

	blockSequencer sequencer (.clk, .rst, .scanRun, .bitsValid, .bitsIn, .outIdle,
		.matchLen, .symRun, .symSize, .compareEn, .selectEn, .rdClass, .window,
		.readBusy, .amplitude, .predictEn, .isDc, .component, .bitsUsed,
		.bitsUsedWidth, .coefValid, .coefBlock, .coefPos, .coefRun, .blockDone,
		.doneBlock);

	coefReconstruct reconstruct (.clk, .rst, .scanRun, .predictEn, .isDc,
		.component, .amplitude, .quantData, .coefData);

endmodule

// File: logic/coefReconstruct.sv
// DC predictors per component and dequantising multiply
`timescale 1ns/1ns

module coefReconstruct (
	input  logic clk,
	input  logic rst,
	input  logic scanRun,
	input  logic predictEn,
	input  logic isDc,
	input  logic [1:0] component,
	input  jpegPkg::coefVal amplitude,
	input  jpegPkg::quantVal quantData,
	output jpegPkg::coefVal coefData
);

	jpegPkg::coefVal dcPred [decodePkg::NumComponents];
	jpegPkg::coefVal dcSum;
	jpegPkg::coefVal value;                 // Predicted or AC coefficient
	logic signed [24:0] product;

	assign dcSum = amplitude + dcPred[component];

	// ---------------------------------------------------------
	// DC prediction
	// ---------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst || !scanRun) begin
			for (int i = 0; i < decodePkg::NumComponents; i++) begin
				dcPred[i] <= '0;                    // Restart at each scan
			end
		end else if (predictEn && isDc) begin
			dcPred[component] <= dcSum;
		end
	end

	always_ff @(posedge clk) begin
		if (predictEn) begin
			value <= isDc ? dcSum : amplitude;      // AC passes through
		end
	end

	// ---------------------------------------------------------
	// Dequantise
	// ---------------------------------------------------------
	assign product = value * $signed({1'b0, quantData});
	assign coefData = product[15:0];

endmodule

// File: huffDecode/blockSequencer.sv
// Symbol FSM, bit window, zig-zag position, block counter and amplitude decode
`timescale 1ns/1ns

module blockSequencer (
	input  logic clk,
	input  logic rst,
	input  logic scanRun,
	input  logic bitsValid,
	input  jpegPkg::bitWindow bitsIn,
	input  logic outIdle,
	input  jpegPkg::codeLen matchLen,
	input  jpegPkg::runLen symRun,
	input  jpegPkg::ampSize symSize,
	output logic compareEn,
	output logic selectEn,
	output jpegPkg::tableClass rdClass,
	output jpegPkg::bitWindow window,
	output logic readBusy,
	output jpegPkg::coefVal amplitude,
	output logic predictEn,
	output logic isDc,
	output logic [1:0] component,
	output logic bitsUsed,
	output jpegPkg::useWidth bitsUsedWidth,
	output logic coefValid,
	output jpegPkg::blockId coefBlock,
	output jpegPkg::coefPos coefPos,
	output jpegPkg::runLen coefRun,
	output logic blockDone,
	output jpegPkg::blockId doneBlock
);

	localparam jpegPkg::coefPos EndPos = jpegPkg::coefPos'(jpegPkg::BlockCoefs - 1);

	decodePkg::seqState state;
	logic emitCoef;                         // Symbol carries a coefficient
	logic chroma;
	logic winTake;
	logic [4:0] codeBits;                   // Code length, 1 to 16
	logic [15:0] ampBits;
	jpegPkg::coefVal ampSigned;

	assign winTake = (state == decodePkg::fetch) && bitsValid && outIdle;
	assign codeBits = {1'b0, matchLen} + 5'd1;

	// ---------------------------------------------------------
	// Table class and component
	// ---------------------------------------------------------
	assign chroma = coefBlock > jpegPkg::LastLumaBlock;
	assign rdClass = {chroma, coefPos != '0};
	assign isDc = coefPos == '0;
	assign component = !chroma ? 2'd0 : (coefBlock == jpegPkg::LastBlock) ? 2'd2 : 2'd1;

	// Amplitude sits at the top of the shifted window
	assign ampBits = window[31:16] >> (5'd16 - {1'b0, symSize});

	always_comb begin
		if (symSize == '0 || window[31]) begin
			ampSigned = ampBits;
		end else begin
			ampSigned = ampBits - (16'd1 << symSize) + 16'd1;    // Leading 0 means negative
		end
	end

	// ---------------------------------------------------------
	// Control FSM
	// ---------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= decodePkg::idle;
			coefPos <= '0;
			coefBlock <= '0;
			emitCoef <= 1'b0;
			blockDone <= 1'b0;
		end else begin
			blockDone <= 1'b0;
			case (state)
				decodePkg::idle: begin
					coefPos <= '0;
					coefBlock <= '0;
					if (scanRun) begin
						state <= decodePkg::fetch;
					end
				end
				decodePkg::fetch: begin
					if (!scanRun) begin
						state <= decodePkg::idle;
					end else if (winTake) begin
						state <= decodePkg::compare;
					end
				end
				decodePkg::compare: state <= decodePkg::select;
				decodePkg::select: state <= decodePkg::waitIdle;
				decodePkg::waitIdle: begin
					if (outIdle) begin
						state <= decodePkg::lookup;
					end
				end
				decodePkg::lookup: begin
					state <= decodePkg::predict;
					if (coefPos == '0) begin
						emitCoef <= 1'b1;                       // DC always emits
					end else if (symSize == '0 && symRun == '0) begin
						coefPos <= EndPos;                      // End of block
						emitCoef <= 1'b0;
					end else if (symSize == '0 && symRun == jpegPkg::ZrlRun) begin
						coefPos <= coefPos + jpegPkg::coefPos'(jpegPkg::ZrlRun);
						emitCoef <= 1'b0;
					end else begin
						coefPos <= coefPos + jpegPkg::coefPos'(symRun);
						emitCoef <= 1'b1;
					end
				end
				decodePkg::predict: state <= decodePkg::emit;
				decodePkg::emit: begin
					state <= decodePkg::fetch;
					if (coefPos == EndPos) begin
						coefPos <= '0;
						blockDone <= 1'b1;
						coefBlock <= (coefBlock == jpegPkg::LastBlock) ? '0 : coefBlock + 3'd1;
					end else begin
						coefPos <= coefPos + 6'd1;
					end
				end
				default: state <= decodePkg::idle;
			endcase
		end
	end

	// ---------------------------------------------------------
	// Window and symbol payload
	// ---------------------------------------------------------
	always_ff @(posedge clk) begin
		if (winTake) begin
			window <= bitsIn;
		end else if (state == decodePkg::waitIdle && outIdle) begin
			window <= window << codeBits;           // Drop the matched code
		end
		if (state == decodePkg::lookup) begin
			amplitude <= ampSigned;
			coefRun <= symRun;
			bitsUsedWidth <= jpegPkg::useWidth'(codeBits) + jpegPkg::useWidth'(symSize);
		end
		if (state == decodePkg::emit) begin
			doneBlock <= coefBlock;
		end
	end

	assign compareEn = state == decodePkg::compare;
	assign selectEn = state == decodePkg::select;
	assign readBusy = compareEn || selectEn;    // Matcher reads the table
	assign predictEn = state == decodePkg::predict;
	assign bitsUsed = state == decodePkg::predict;
	assign coefValid = (state == decodePkg::emit) && emitCoef;

endmodule

// File: huffDecode/codeMatcher.sv
// Leading-code compare, code length select and symbol index computation
`timescale 1ns/1ns

module codeMatcher (
	input  logic clk,
	input  logic rst,
	input  logic compareEn,
	input  logic selectEn,
	input  jpegPkg::bitWindow window,
	input  jpegPkg::huffCode minCodes [jpegPkg::NumCodeLens],
	input  jpegPkg::symIndex baseIndex [jpegPkg::NumCodeLens],
	output jpegPkg::codeLen matchLen,
	output jpegPkg::symIndex symAddr
);

	logic [jpegPkg::NumCodeLens-1:0] geMin;     // Window at or above each minimum
	logic [jpegPkg::NumCodeLens-1:0] flags;
	logic runOk;
	jpegPkg::codeLen bestLen;
	jpegPkg::huffCode codeBits;
	jpegPkg::huffCode minBits;

	// ---------------------------------------------------------
	// Compare stage
	// ---------------------------------------------------------
	always_comb begin
		for (int i = 0; i < jpegPkg::NumCodeLens; i++) begin
			geMin[i] = window[31:16] >= minCodes[i];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			flags <= '0;
		end else if (compareEn) begin
			flags <= geMin;
		end
	end

	// ---------------------------------------------------------
	// Select stage
	// ---------------------------------------------------------
	// Longest unbroken run of flags from length 1 upward
	always_comb begin
		runOk = 1'b1;
		bestLen = '0;
		for (int i = 0; i < jpegPkg::NumCodeLens; i++) begin
			runOk = runOk & flags[i];
			if (runOk) begin
				bestLen = jpegPkg::codeLen'(i);
			end
		end
	end

	// Right-aligned leading code and minimum code of that length
	assign codeBits = window[31:16] >> (4'd15 - bestLen);
	assign minBits = minCodes[bestLen] >> (4'd15 - bestLen);

	always_ff @(posedge clk) begin
		if (!rst) begin
			matchLen <= '0;
		end else if (selectEn) begin
			matchLen <= bestLen;
		end
	end

	always_ff @(posedge clk) begin
		if (selectEn) begin
			symAddr <= baseIndex[bestLen] + jpegPkg::symIndex'(codeBits - minBits);
		end
	end

	// Canonical tables give minimum codes that rise with length
	assert property (@(posedge clk) disable iff (!rst)
		selectEn |-> (flags & (flags + 1'b1)) == '0)
		else $error("compare flags not contiguous: %h", flags);

endmodule

// File: huffDecode/huffTableBank.sv
// Storage of the four Huffman code tables and per-class table read
`timescale 1ns/1ns

module huffTableBank (
	input  logic clk,
	input  logic rst,
	input  logic tableWrite,
	input  jpegPkg::tableClass tableWrClass,
	input  jpegPkg::codeLen tableWrLen,
	input  jpegPkg::huffCode tableWrCode,
	input  jpegPkg::symIndex tableWrBase,
	input  jpegPkg::tableClass rdClass,
	input  logic readBusy,
	output jpegPkg::huffCode minCodes [jpegPkg::NumCodeLens],
	output jpegPkg::symIndex baseIndex [jpegPkg::NumCodeLens]
);

	// One table per class: luma DC, luma AC, chroma DC, chroma AC
	jpegPkg::huffCode minTab [4][jpegPkg::NumCodeLens];
	jpegPkg::symIndex baseTab [4][jpegPkg::NumCodeLens];

	// ---------------------------------------------------------
	// Table write
	// ---------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int c = 0; c < 4; c++) begin
				for (int l = 0; l < jpegPkg::NumCodeLens; l++) begin
					minTab[c][l] <= '0;
					baseTab[c][l] <= '0;
				end
			end
		end else if (tableWrite) begin
			minTab[tableWrClass][tableWrLen] <= tableWrCode;    // Visible next cycle
			baseTab[tableWrClass][tableWrLen] <= tableWrBase;
		end
	end

	// ---------------------------------------------------------
	// Table read
	// ---------------------------------------------------------
	assign minCodes = minTab[rdClass];      // Whole table of one class
	assign baseIndex = baseTab[rdClass];

	// A table must not change under the matcher while it compares and selects
	assert property (@(posedge clk) disable iff (!rst)
		tableWrite && readBusy |-> tableWrClass != rdClass)
		else $error("table write to class %0d during decode", tableWrClass);

endmodule

// File: common/decodePkg.sv
// Decoder FSM state encoding and predictor count
package decodePkg;

	// ---------------------------------------------------------
	// Sequencer states
	// ---------------------------------------------------------
	typedef enum logic [2:0] {
		idle,           // Scan not running
		fetch,          // Wait for a bit window
		compare,        // Compare against minimum codes
		select,         // Pick code length and symbol index
		waitIdle,       // Hold for downstream, shift window
		lookup,         // Run and size from symbol memory
		predict,        // DC prediction, bits-used reply
		emit            // Coefficient out, position advance
	} seqState;

	localparam int NumComponents = 3;       // Y, Cb, Cr

endpackage

// File: common/jpegPkg.sv
// JPEG entropy-coding vector types and format constants
package jpegPkg;

	// ---------------------------------------------------------
	// Vector types
	// ---------------------------------------------------------
	typedef logic [31:0] bitWindow;         // Entropy-coded bits, MSB first
	typedef logic [15:0] huffCode;          // Left-aligned minimum code
	typedef logic [7:0] symIndex;           // Symbol memory address
	typedef logic [3:0] codeLen;            // Code length minus one
	typedef logic [3:0] runLen;             // Zeros ahead of a coefficient
	typedef logic [3:0] ampSize;            // Amplitude width in bits
	typedef logic signed [15:0] coefVal;    // Coefficient value
	typedef logic [7:0] quantVal;           // Quantiser step
	typedef logic [5:0] coefPos;            // Zig-zag position
	typedef logic [2:0] blockId;            // Block number inside the MCU

	// Upper bit selects chroma, lower bit selects AC
	typedef logic [1:0] tableClass;

	typedef logic [6:0] useWidth;           // Bits consumed per symbol

	// ---------------------------------------------------------
	// Format constants
	// ---------------------------------------------------------
	localparam int NumCodeLens = 16;        // Code lengths 1 to 16
	localparam int BlockCoefs = 64;         // Coefficients per 8x8 block

	// Four luma blocks, then Cb, then Cr
	localparam blockId LastBlock = 3'd5;
	localparam blockId LastLumaBlock = 3'd3;

	localparam runLen ZrlRun = 4'd15;       // Run of a ZRL symbol

endpackage
